// ==== dv/rs_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_asserts (
	input wire logic                                     clock,
	input wire logic                                     reset,
	input wire logic [rs_pkg::SS_SIZE-1:0]               inst_in_valid,
	input wire logic                                     squash,
	input wire logic [rs_pkg::NUM_FU-1:0]                issue,
	input wire logic [rs_pkg::NUM_FU*rs_pkg::ROW_W-1:0]  inst_out,
	input wire logic [rs_pkg::CREDIT_W-1:0]              num_can_dispatch
);

	// host never offers more lanes than the credit of that cycle
	credit_respected: assert property (@(posedge clock) disable iff (reset)
		$countones(inst_in_valid) <= num_can_dispatch)
		else $error("more lanes offered than dispatch credit");

	// nothing leaves the station right after a squash
	quiet_after_squash: assert property (@(posedge clock) disable iff (reset)
		squash |=> (issue == '0))
		else $error("issue seen in the cycle after squash");

	//////////////////////////////
	// issued rows are complete
	//////////////////////////////

	for (genvar p = 0; p < rs_pkg::NUM_FU; p++) begin : g_port
		issued_row_ready: assert property (@(posedge clock) disable iff (reset)
			issue[p] |-> (inst_out[p*rs_pkg::ROW_W + rs_pkg::ROW_VALID]
				&& inst_out[p*rs_pkg::ROW_W + rs_pkg::ROW_SRC1_RDY]
				&& inst_out[p*rs_pkg::ROW_W + rs_pkg::ROW_SRC2_RDY]))
			else $error("issued row on port %0d is not valid and ready", p);
	end

endmodule

bind rs_top rs_asserts u_asserts (.*);

`default_nettype wire

// ==== dv/rs_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_tb;

	localparam int MAX_STEPS = 40;
	localparam int N_RAND = 60;
	localparam int DRAIN = 40;
	// reset, table, random pairs, drain and some slack
	localparam int WATCH_CYCLES = 8 + MAX_STEPS + 2*N_RAND + DRAIN + 100;

	logic clock;
	logic reset;
	logic [rs_pkg::SS_SIZE-1:0]               inst_in_valid;
	logic [rs_pkg::SS_SIZE*rs_pkg::ROW_W-1:0] inst_in;
	logic                                     dispatch_hazard;
	logic                                     squash;
	logic [rs_pkg::SS_SIZE-1:0]               cdb_valid;
	logic [rs_pkg::SS_SIZE*rs_pkg::TAG_W-1:0] cdb_tag;
	logic [1:0]                               lsq_busy;
	logic [rs_pkg::NUM_FU-1:0]                issue;
	logic [rs_pkg::NUM_FU*rs_pkg::ROW_W-1:0]  inst_out;
	logic [rs_pkg::CREDIT_W-1:0]              num_can_dispatch;

	// directed table, expectations hold for the cycle after the step
	int                                 t_test[MAX_STEPS];
	logic [1:0]                         t_valid[MAX_STEPS];
	logic [2*rs_pkg::ROW_W-1:0]         t_rows[MAX_STEPS];
	logic [1:0]                         t_cv[MAX_STEPS];
	logic [11:0]                        t_ct[MAX_STEPS];
	logic [1:0]                         t_lsq[MAX_STEPS];
	// bit 1 squash, bit 0 hazard
	logic [1:0]                         t_sqhz[MAX_STEPS];
	logic [1:0]                         e_iss[MAX_STEPS];
	logic [11:0]                        e_dest[MAX_STEPS];
	logic [1:0]                         e_ncd[MAX_STEPS];
	int n_steps;
	string test_name[7];

	int errors;
	int checks;
	int test_err;
	// scoreboard for the random phase
	int pending[64];
	int n_sent;
	int n_issued;
	logic in_random;
	logic [31:0] seed;
	logic [5:0] next_tag;
	logic [5:0] mon_tag;
	logic [2*rs_pkg::ROW_W-1:0] lanes;
	logic [1:0] credit;
	int n_lanes;

	rs_top UUT (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// rdy is {src2 ready, src1 ready}
	function automatic logic [rs_pkg::ROW_W-1:0] make_row(input logic is_mem, input logic store,
		input logic [5:0] dest, input logic [5:0] s1, input logic [5:0] s2, input logic [1:0] rdy);
		logic [rs_pkg::ROW_W-1:0] r;
		rs_pkg::rs_payload_u pay;
		r = '0;
		pay = '0;
		if (is_mem) begin
			pay.mem.mem_store = store;
			pay.mem.mem_offset = {3'd0, dest};
		end else begin
			pay.alu.alu_opcode = 4'h3;
		end
		r[rs_pkg::ROW_VALID] = 1'b1;
		r[rs_pkg::ROW_IS_MEM] = is_mem;
		r[rs_pkg::ROW_DEST +: rs_pkg::TAG_W] = dest;
		r[rs_pkg::ROW_SRC1 +: rs_pkg::TAG_W] = s1;
		r[rs_pkg::ROW_SRC1_RDY] = rdy[0];
		r[rs_pkg::ROW_SRC2 +: rs_pkg::TAG_W] = s2;
		r[rs_pkg::ROW_SRC2_RDY] = rdy[1];
		r[rs_pkg::ROW_PAYLOAD +: rs_pkg::PAYLOAD_W] = pay;
		return r;
	endfunction

	task automatic st(input int test, input logic [1:0] v, input logic [rs_pkg::ROW_W-1:0] r0,
		input logic [rs_pkg::ROW_W-1:0] r1, input logic [1:0] cv, input logic [11:0] ct,
		input logic [1:0] lsq, input logic [1:0] sqhz, input logic [1:0] ei,
		input logic [11:0] ed, input logic [1:0] encd);
		t_test[n_steps] = test;
		t_valid[n_steps] = v;
		t_rows[n_steps] = {r1, r0};
		t_cv[n_steps] = cv;
		t_ct[n_steps] = ct;
		t_lsq[n_steps] = lsq;
		t_sqhz[n_steps] = sqhz;
		e_iss[n_steps] = ei;
		e_dest[n_steps] = ed;
		e_ncd[n_steps] = encd;
		n_steps++;
	endtask

	task automatic drive(input logic [1:0] v, input logic [2*rs_pkg::ROW_W-1:0] rows_in,
		input logic [1:0] cv, input logic [11:0] ct, input logic [1:0] lsq, input logic [1:0] sqhz);
		inst_in_valid <= v;
		inst_in <= rows_in;
		cdb_valid <= cv;
		cdb_tag <= ct;
		lsq_busy <= lsq;
		squash <= sqhz[1];
		dispatch_hazard <= sqhz[0];
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_step(input int k);
		compare("issue", issue, e_iss[k]);
		for (int p = 0; p < rs_pkg::NUM_FU; p++) begin
			if (e_iss[k][p]) begin
				compare($sformatf("inst_out[%0d] dest", p),
					inst_out[p*rs_pkg::ROW_W + rs_pkg::ROW_DEST +: rs_pkg::TAG_W],
					e_dest[k][p*6 +: 6]);
			end
		end
		compare("num_can_dispatch", num_can_dispatch, e_ncd[k]);
	endtask

	task automatic report_test(input int t);
		$display("test %0d %s: %s (%0d errors)", t, test_name[t],
			(errors == test_err) ? "ok" : "failed", errors - test_err);
		test_err = errors;
	endtask

	//////////////////////////////
	// clock, reset, watchdog
	//////////////////////////////

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		repeat (WATCH_CYCLES) @(posedge clock);
		$display("watchdog expired, the run did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

	// random phase scoreboard, every issued tag must be pending exactly once
	always @(negedge clock) begin
		if (in_random) begin
			for (int p = 0; p < rs_pkg::NUM_FU; p++) begin
				if (issue[p]) begin
					mon_tag = inst_out[p*rs_pkg::ROW_W + rs_pkg::ROW_DEST +: rs_pkg::TAG_W];
					compare("inst_out is_mem", inst_out[p*rs_pkg::ROW_W + rs_pkg::ROW_IS_MEM], p);
					if (pending[mon_tag] != 1) begin
						errors++;
						$display("tag %0d issued at %0t without a matching dispatch", mon_tag, $time);
					end else begin
						pending[mon_tag] = 0;
						n_issued++;
					end
				end
			end
		end
	end

	initial begin
		reset = 1'b1;
		inst_in_valid = '0;
		inst_in = '0;
		dispatch_hazard = 1'b0;
		squash = 1'b0;
		cdb_valid = '0;
		cdb_tag = '0;
		lsq_busy = '0;
		errors = 0;
		checks = 0;
		test_err = 0;
		n_steps = 0;
		n_sent = 0;
		n_issued = 0;
		in_random = 1'b0;
		seed = 32'h1714426e;
		next_tag = '0;
		for (int i = 0; i < 64; i++) begin
			pending[i] = 0;
		end
		test_name = '{"reset", "dual issue and age order", "wakeup", "queue busy",
			"fill and hazard", "squash", "random"};

		// test, valid, lane 0, lane 1, cdb valid, cdb tags, lsq, sq/hz, issue, dests, credit
		st(0, 0, '0, '0, 0, 0, 0, 0, 0, 0, 2);
		st(1, 3, make_row(0, 0, 10, 1, 2, 3), make_row(1, 0, 11, 1, 2, 3), 0, 0, 0, 0, 0, 0, 2);
		st(1, 0, '0, '0, 0, 0, 0, 0, 3, {6'd11, 6'd10}, 2);
		st(1, 3, make_row(0, 0, 20, 1, 2, 3), make_row(0, 0, 21, 1, 2, 3), 0, 0, 0, 0, 0, 0, 2);
		st(1, 1, make_row(0, 0, 22, 1, 2, 3), '0, 0, 0, 0, 0, 1, {6'd0, 6'd20}, 2);
		st(1, 0, '0, '0, 0, 0, 0, 0, 1, {6'd0, 6'd21}, 2);
		st(1, 0, '0, '0, 0, 0, 0, 0, 1, {6'd0, 6'd22}, 2);
		st(1, 0, '0, '0, 0, 0, 0, 0, 0, 0, 2);
		// src1 waits on 40, then 42 arrives in the dispatch cycle
		st(2, 1, make_row(0, 0, 30, 40, 41, 2), '0, 0, 0, 0, 0, 0, 0, 2);
		st(2, 0, '0, '0, 0, 0, 0, 0, 0, 0, 2);
		st(2, 0, '0, '0, 1, {6'd0, 6'd40}, 0, 0, 0, 0, 2);
		st(2, 0, '0, '0, 0, 0, 0, 0, 1, {6'd0, 6'd30}, 2);
		st(2, 1, make_row(0, 0, 31, 42, 43, 2), '0, 2, {6'd42, 6'd0}, 0, 0, 0, 0, 2);
		st(2, 0, '0, '0, 0, 0, 0, 0, 1, {6'd0, 6'd31}, 2);
		st(2, 0, '0, '0, 0, 0, 0, 0, 0, 0, 2);
		// load 50, store 51, alu 52 passes the blocked queues
		st(3, 3, make_row(1, 0, 50, 1, 2, 3), make_row(1, 1, 51, 1, 2, 3), 0, 0, 3, 0, 0, 0, 2);
		st(3, 1, make_row(0, 0, 52, 1, 2, 3), '0, 0, 0, 3, 0, 0, 0, 2);
		st(3, 0, '0, '0, 0, 0, 3, 0, 1, {6'd0, 6'd52}, 2);
		st(3, 0, '0, '0, 0, 0, 2, 0, 2, {6'd50, 6'd0}, 2);
		st(3, 0, '0, '0, 0, 0, 2, 0, 0, 0, 2);
		st(3, 0, '0, '0, 0, 0, 0, 0, 2, {6'd51, 6'd0}, 2);
		st(3, 0, '0, '0, 0, 0, 0, 0, 0, 0, 2);
		// sources 60 and 61 never ready
		st(4, 3, make_row(0, 0, 1, 60, 61, 0), make_row(0, 0, 2, 60, 61, 0), 0, 0, 0, 0, 0, 0, 2);
		st(4, 3, make_row(0, 0, 3, 60, 61, 0), make_row(0, 0, 4, 60, 61, 0), 0, 0, 0, 0, 0, 0, 2);
		st(4, 3, make_row(0, 0, 5, 60, 61, 0), make_row(0, 0, 6, 60, 61, 0), 0, 0, 0, 1, 0, 0, 2);
		st(4, 3, make_row(0, 0, 5, 60, 61, 0), make_row(0, 0, 6, 60, 61, 0), 0, 0, 0, 0, 0, 0, 2);
		st(4, 3, make_row(0, 0, 7, 60, 61, 0), make_row(0, 0, 8, 60, 61, 0), 0, 0, 0, 0, 0, 0, 0);
		st(4, 0, '0, '0, 0, 0, 0, 0, 0, 0, 0);
		// wake the full station so the squash cycle holds ready rows
		st(5, 0, '0, '0, 3, {6'd61, 6'd60}, 0, 0, 0, 0, 0);
		st(5, 0, '0, '0, 0, 0, 0, 2, 0, 0, 0);
		st(5, 0, '0, '0, 0, 0, 0, 0, 0, 0, 2);
		st(5, 0, '0, '0, 3, {6'd61, 6'd60}, 0, 0, 0, 0, 2);
		st(5, 0, '0, '0, 0, 0, 0, 0, 0, 0, 2);

		repeat (8) @(posedge clock);
		reset <= 1'b0;

		//////////////////////////////
		// directed table
		//////////////////////////////

		for (int i = 0; i <= n_steps; i++) begin
			@(posedge clock);
			if (i < n_steps) begin
				drive(t_valid[i], t_rows[i], t_cv[i], t_ct[i], t_lsq[i], t_sqhz[i]);
			end else begin
				drive(0, '0, 0, 0, 0, 0);
			end
			@(negedge clock);
			if (i > 0) begin
				check_step(i - 1);
				if ((i == n_steps) || (t_test[i] != t_test[i-1])) begin
					report_test(t_test[i-1]);
				end
			end
		end

		//////////////////////////////
		// random phase
		//////////////////////////////

		in_random = 1'b1;
		for (int k = 0; k < N_RAND; k++) begin
			@(posedge clock);
			// credit of the cycle just ended, only grows until the next offer
			credit = num_can_dispatch;
			seed = xorshift(seed);
			n_lanes = seed % (credit + 1);
			lanes = '0;
			for (int l = 0; l < n_lanes; l++) begin
				if (pending[next_tag] != 0) begin
					errors++;
					$display("tag %0d still waiting when reused", next_tag);
				end
				pending[next_tag] = 1;
				n_sent++;
				lanes[l*rs_pkg::ROW_W +: rs_pkg::ROW_W] =
					make_row(seed[8+l], seed[10+l], next_tag, seed[20 +: 6], seed[26 +: 6], 3);
				next_tag = next_tag + 1'b1;
			end
			drive((n_lanes == 2) ? 2'b11 : (n_lanes == 1) ? 2'b01 : 2'b00, lanes, 0, 0,
				seed[15:14] & seed[17:16], 0);
			@(posedge clock);
			drive(0, '0, 0, 0, seed[15:14] & seed[17:16], 0);
		end
		@(posedge clock);
		drive(0, '0, 0, 0, 0, 0);
		for (int w = 0; (w < DRAIN) && (n_issued < n_sent); w++) begin
			@(negedge clock);
		end
		repeat (2) @(negedge clock);
		in_random = 1'b0;
		if (n_issued != n_sent) begin
			errors++;
			$display("random phase: %0d of %0d rows never issued", n_sent - n_issued, n_sent);
		end
		report_test(6);

		$display("checks %0d, errors %0d, random rows %0d", checks, errors, n_sent);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rs.f ====
rtl/rs_pkg.sv
rtl/rs_control_fsm.sv
rtl/rs_occupancy_counter.sv
rtl/rs_entry_table.sv
rtl/rs_issue_selector.sv
rtl/rs_top.sv
dv/rs_asserts.sv
dv/rs_tb.sv

// ==== rtl/rs_control_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_control_fsm (
	input  wire logic                         clock,
	input  wire logic                         reset,
	input  wire logic                         squash,
	input  wire logic                         dispatch_hazard,
	input  wire logic [rs_pkg::SS_SIZE-1:0]   inst_in_valid,
	input  wire logic [rs_pkg::CNT_W-1:0]     busy_rows,
	output logic      [rs_pkg::STATE_W-1:0]   state,
	output logic                              dispatch_en,
	output logic                              issue_en,
	output logic                              clear
);

	logic [rs_pkg::STATE_W-1:0] state_next;
	// at least one lane actually gets written this cycle
	logic dispatch_take;

	//////////////////////////////
	// enables
	//////////////////////////////

	// a squash in the current cycle already blocks writes and picks,
	// so nothing new lands in front of the clear
	assign dispatch_en = (state != rs_pkg::ST_SQUASH) && !dispatch_hazard && !squash;
	assign issue_en = (state == rs_pkg::ST_RUN) && !squash;
	assign clear = (state == rs_pkg::ST_SQUASH);
	assign dispatch_take = dispatch_en && (|inst_in_valid);

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			rs_pkg::ST_IDLE: begin
				// leave idle on the first write
				if (dispatch_take || (busy_rows != '0)) begin
					state_next = rs_pkg::ST_RUN;
				end
			end
			rs_pkg::ST_RUN: begin
				// drained and nothing arriving
				if ((busy_rows == '0) && !dispatch_take) begin
					state_next = rs_pkg::ST_IDLE;
				end
			end
			rs_pkg::ST_SQUASH: begin
				// one cycle of clearing only
				state_next = rs_pkg::ST_IDLE;
			end
			default: begin
				state_next = rs_pkg::ST_IDLE;
			end
		endcase
		// squash wins over every state
		if (squash) begin
			state_next = rs_pkg::ST_SQUASH;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= rs_pkg::ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/rs_entry_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_entry_table (
	input  wire logic                                        clock,
	input  wire logic                                        reset,
	input  wire logic                                        dispatch_en,
	input  wire logic                                        clear,
	input  wire logic [rs_pkg::SS_SIZE-1:0]                  inst_in_valid,
	input  wire logic [rs_pkg::SS_SIZE*rs_pkg::ROW_W-1:0]    inst_in,
	input  wire logic [rs_pkg::SS_SIZE-1:0]                  cdb_valid,
	input  wire logic [rs_pkg::SS_SIZE*rs_pkg::TAG_W-1:0]    cdb_tag,
	input  wire logic [rs_pkg::NUM_FU-1:0]                   pick_valid,
	input  wire logic [rs_pkg::NUM_FU*rs_pkg::RS_SIZE-1:0]   pick_row,
	output logic      [rs_pkg::RS_SIZE*rs_pkg::ROW_W-1:0]    rows,
	output logic      [rs_pkg::CREDIT_W-1:0]                 accept_cnt,
	output logic      [rs_pkg::CREDIT_W-1:0]                 issue_cnt,
	output logic      [rs_pkg::NUM_FU-1:0]                   issue,
	output logic      [rs_pkg::NUM_FU*rs_pkg::ROW_W-1:0]     inst_out
);

	logic [rs_pkg::RS_SIZE*rs_pkg::ROW_W-1:0] rows_next;
	logic [rs_pkg::NUM_FU*rs_pkg::ROW_W-1:0]  out_next;
	// rows leaving through either port
	logic [rs_pkg::RS_SIZE-1:0]               picked;

	// set the ready bit of any source whose tag is on a valid bus lane
	function automatic logic [rs_pkg::ROW_W-1:0] wake_row(
		input logic [rs_pkg::ROW_W-1:0]                 row_in,
		input logic [rs_pkg::SS_SIZE-1:0]               bus_valid,
		input logic [rs_pkg::SS_SIZE*rs_pkg::TAG_W-1:0] bus_tag
	);
		logic [rs_pkg::ROW_W-1:0] row_out;
		logic [rs_pkg::TAG_W-1:0] tag;
		row_out = row_in;
		for (int b = 0; b < rs_pkg::SS_SIZE; b++) begin
			tag = bus_tag[b*rs_pkg::TAG_W +: rs_pkg::TAG_W];
			if (bus_valid[b]) begin
				if (row_in[rs_pkg::ROW_SRC1 +: rs_pkg::TAG_W] == tag) begin
					row_out[rs_pkg::ROW_SRC1_RDY] = 1'b1;
				end
				if (row_in[rs_pkg::ROW_SRC2 +: rs_pkg::TAG_W] == tag) begin
					row_out[rs_pkg::ROW_SRC2_RDY] = 1'b1;
				end
			end
		end
		return row_out;
	endfunction

	//////////////////////////////
	// issue side
	//////////////////////////////

	// one-hot pick per port muxes the row straight out
	always_comb begin
		picked = '0;
		out_next = '0;
		issue_cnt = '0;
		for (int p = 0; p < rs_pkg::NUM_FU; p++) begin
			if (pick_valid[p]) begin
				issue_cnt = issue_cnt + 1'b1;
				for (int r = 0; r < rs_pkg::RS_SIZE; r++) begin
					if (pick_row[p*rs_pkg::RS_SIZE + r]) begin
						picked[r] = 1'b1;
						out_next[p*rs_pkg::ROW_W +: rs_pkg::ROW_W] =
							rows[r*rs_pkg::ROW_W +: rs_pkg::ROW_W];
					end
				end
			end
		end
	end

	//////////////////////////////
	// compaction and append
	//////////////////////////////

	always_comb begin
		logic [rs_pkg::ROW_W-1:0] cur;
		int wr;
		rows_next = '0;
		accept_cnt = '0;
		wr = 0;
		// survivors close up toward row 0, keeping age order
		for (int r = 0; r < rs_pkg::RS_SIZE; r++) begin
			cur = rows[r*rs_pkg::ROW_W +: rs_pkg::ROW_W];
			if (cur[rs_pkg::ROW_VALID] && !picked[r]) begin
				rows_next[wr*rs_pkg::ROW_W +: rs_pkg::ROW_W] =
					wake_row(cur, cdb_valid, cdb_tag);
				wr = wr + 1;
			end
		end
		// new lanes go behind them in lane order
		for (int l = 0; l < rs_pkg::SS_SIZE; l++) begin
			cur = inst_in[l*rs_pkg::ROW_W +: rs_pkg::ROW_W];
			cur[rs_pkg::ROW_VALID] = 1'b1;
			// a broadcast in the dispatch cycle counts too
			if (dispatch_en && inst_in_valid[l] && (wr < rs_pkg::RS_SIZE)) begin
				rows_next[wr*rs_pkg::ROW_W +: rs_pkg::ROW_W] =
					wake_row(cur, cdb_valid, cdb_tag);
				wr = wr + 1;
				accept_cnt = accept_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////
	// registers
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || clear) begin
			rows <= '0;
		end else begin
			rows <= rows_next;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			issue <= '0;
		end else if (clear) begin
			issue <= '0;
		end else begin
			issue <= pick_valid;
		end
	end

	// only meaningful where issue is set
	always_ff @(posedge clock) begin
		inst_out <= out_next;
	end

endmodule

`default_nettype wire

// ==== rtl/rs_issue_selector.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_issue_selector (
	input  wire logic [rs_pkg::RS_SIZE*rs_pkg::ROW_W-1:0]    rows,
	input  wire logic                                        issue_en,
	input  wire logic [1:0]                                  lsq_busy,
	output logic      [rs_pkg::NUM_FU-1:0]                   pick_valid,
	output logic      [rs_pkg::NUM_FU*rs_pkg::RS_SIZE-1:0]   pick_row
);

	// candidates per class
	logic [rs_pkg::RS_SIZE-1:0] alu_req;
	logic [rs_pkg::RS_SIZE-1:0] mem_req;
	// lowest set bit of each request vector
	logic [rs_pkg::RS_SIZE-1:0] alu_pick;
	logic [rs_pkg::RS_SIZE-1:0] mem_pick;

	//////////////////////////////
	// per-row readiness
	//////////////////////////////

	always_comb begin
		logic [rs_pkg::ROW_W-1:0] row;
		rs_pkg::rs_payload_u pay;
		logic rdy;
		alu_req = '0;
		mem_req = '0;
		for (int r = 0; r < rs_pkg::RS_SIZE; r++) begin
			row = rows[r*rs_pkg::ROW_W +: rs_pkg::ROW_W];
			pay = row[rs_pkg::ROW_PAYLOAD +: rs_pkg::PAYLOAD_W];
			rdy = row[rs_pkg::ROW_VALID]
				&& row[rs_pkg::ROW_SRC1_RDY]
				&& row[rs_pkg::ROW_SRC2_RDY];
			if (row[rs_pkg::ROW_IS_MEM]) begin
				// lsq_busy bit 0 = load queue, bit 1 = store queue
				mem_req[r] = rdy && !lsq_busy[pay.mem.mem_store];
			end else begin
				alu_req[r] = rdy;
			end
		end
	end

	//////////////////////////////
	// oldest first
	//////////////////////////////

	// row 0 is the oldest, so the lowest index wins
	assign alu_pick = alu_req & (~alu_req + 1'b1);
	assign mem_pick = mem_req & (~mem_req + 1'b1);

	always_comb begin
		pick_row = '0;
		pick_valid = '0;
		if (issue_en) begin
			pick_row[rs_pkg::PORT_ALU*rs_pkg::RS_SIZE +: rs_pkg::RS_SIZE] = alu_pick;
			pick_row[rs_pkg::PORT_MEM*rs_pkg::RS_SIZE +: rs_pkg::RS_SIZE] = mem_pick;
			pick_valid[rs_pkg::PORT_ALU] = |alu_req;
			pick_valid[rs_pkg::PORT_MEM] = |mem_req;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/rs_occupancy_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_occupancy_counter (
	input  wire logic                         clock,
	input  wire logic                         reset,
	input  wire logic                         clear,
	input  wire logic [rs_pkg::CREDIT_W-1:0]  accept_cnt,
	input  wire logic [rs_pkg::CREDIT_W-1:0]  issue_cnt,
	input  wire logic                         state_squash,
	output logic      [rs_pkg::CNT_W-1:0]     busy_rows,
	output logic      [rs_pkg::CREDIT_W-1:0]  num_can_dispatch
);

	logic [rs_pkg::CNT_W-1:0] busy_next;
	logic [rs_pkg::CNT_W-1:0] free_rows;

	//////////////////////////////
	// occupancy
	//////////////////////////////

	// writes and removals land on the same edge, so one update
	assign busy_next = busy_rows
		+ rs_pkg::CNT_W'(accept_cnt)
		- rs_pkg::CNT_W'(issue_cnt);

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_rows <= '0;
		end else if (clear) begin
			busy_rows <= '0;
		end else begin
			busy_rows <= busy_next;
		end
	end

	//////////////////////////////
	// dispatch credit
	//////////////////////////////

	assign free_rows = rs_pkg::CNT_W'(rs_pkg::RS_SIZE) - busy_rows;

	// based on the registered count only, rows leaving this cycle
	// are not counted as free until the next one
	always_comb begin
		if (state_squash) begin
			num_can_dispatch = '0;
		end else if (free_rows < rs_pkg::CNT_W'(rs_pkg::SS_SIZE)) begin
			num_can_dispatch = free_rows[rs_pkg::CREDIT_W-1:0];
		end else begin
			num_can_dispatch = rs_pkg::CREDIT_W'(rs_pkg::SS_SIZE);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/rs_pkg.sv ====
`default_nettype none

package rs_pkg;

	//////////////////////////////
	// sizes
	//////////////////////////////

	// entries held by the station
	localparam int RS_SIZE = 8;
	// instructions offered per cycle
	localparam int SS_SIZE = 2;
	// issue ports, alu on 0 and load/store on 1
	localparam int NUM_FU = 2;
	localparam int PORT_ALU = 0;
	localparam int PORT_MEM = 1;
	// physical register tag
	localparam int TAG_W = 6;
	// occupancy 0..RS_SIZE
	localparam int CNT_W = 4;
	// credit 0..SS_SIZE, also used for per-cycle accept/issue counts
	localparam int CREDIT_W = 2;
	localparam int PAYLOAD_W = 12;

	//////////////////////////////
	// row layout, lsb first
	//////////////////////////////

	localparam int ROW_VALID = 0;
	// selects which view of the payload applies
	localparam int ROW_IS_MEM = 1;
	localparam int ROW_DEST = 2;
	localparam int ROW_SRC1 = 8;
	localparam int ROW_SRC1_RDY = 14;
	localparam int ROW_SRC2 = 15;
	localparam int ROW_SRC2_RDY = 21;
	localparam int ROW_PAYLOAD = 22;
	localparam int ROW_W = ROW_PAYLOAD + PAYLOAD_W;

	// control fsm encoding
	localparam int STATE_W = 2;
	localparam logic [STATE_W-1:0] ST_IDLE = 2'd0;
	localparam logic [STATE_W-1:0] ST_RUN = 2'd1;
	localparam logic [STATE_W-1:0] ST_SQUASH = 2'd2;

	// payload word, alu or memory view picked by row_is_mem
	typedef union packed {
		struct packed {
			logic [3:0] alu_opcode;
			logic [7:0] alu_imm;
		} alu;
		struct packed {
			// 1 = store, 0 = load
			logic       mem_store;
			logic [1:0] mem_size;
			logic [8:0] mem_offset;
		} mem;
	} rs_payload_u;

endpackage

`default_nettype wire

// ==== rtl/rs_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_top (
	input  wire logic                                        clock,
	input  wire logic                                        reset,
	input  wire logic [rs_pkg::SS_SIZE-1:0]                  inst_in_valid,
	input  wire logic [rs_pkg::SS_SIZE*rs_pkg::ROW_W-1:0]    inst_in,
	input  wire logic                                        dispatch_hazard,
	input  wire logic                                        squash,
	input  wire logic [rs_pkg::SS_SIZE-1:0]                  cdb_valid,
	input  wire logic [rs_pkg::SS_SIZE*rs_pkg::TAG_W-1:0]    cdb_tag,
	// bit 0 load queue busy, bit 1 store queue busy
	input  wire logic [1:0]                                  lsq_busy,
	output logic      [rs_pkg::NUM_FU-1:0]                   issue,
	output logic      [rs_pkg::NUM_FU*rs_pkg::ROW_W-1:0]     inst_out,
	output logic      [rs_pkg::CREDIT_W-1:0]                 num_can_dispatch
);

	// fsm controls
	logic [rs_pkg::STATE_W-1:0]               state;
	logic                                     dispatch_en;
	logic                                     issue_en;
	logic                                     clear;
	// table to selector and back
	logic [rs_pkg::RS_SIZE*rs_pkg::ROW_W-1:0] rows;
	logic [rs_pkg::NUM_FU-1:0]                pick_valid;
	logic [rs_pkg::NUM_FU*rs_pkg::RS_SIZE-1:0] pick_row;
	// occupancy bookkeeping
	logic [rs_pkg::CREDIT_W-1:0]              accept_cnt;
	logic [rs_pkg::CREDIT_W-1:0]              issue_cnt;
	logic [rs_pkg::CNT_W-1:0]                 busy_rows;

	rs_control_fsm u_fsm (
		.clock           (clock),
		.reset           (reset),
		.squash          (squash),
		.dispatch_hazard (dispatch_hazard),
		.inst_in_valid   (inst_in_valid),
		.busy_rows       (busy_rows),
		.state           (state),
		.dispatch_en     (dispatch_en),
		.issue_en        (issue_en),
		.clear           (clear)
	);

	rs_occupancy_counter u_counter (
		.clock            (clock),
		.reset            (reset),
		.clear            (clear),
		.accept_cnt       (accept_cnt),
		.issue_cnt        (issue_cnt),
		.state_squash     (state == rs_pkg::ST_SQUASH),
		.busy_rows        (busy_rows),
		.num_can_dispatch (num_can_dispatch)
	);

	rs_entry_table u_table (
		.clock         (clock),
		.reset         (reset),
		.dispatch_en   (dispatch_en),
		.clear         (clear),
		.inst_in_valid (inst_in_valid),
		.inst_in       (inst_in),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.pick_valid    (pick_valid),
		.pick_row      (pick_row),
		.rows          (rows),
		.accept_cnt    (accept_cnt),
		.issue_cnt     (issue_cnt),
		.issue         (issue),
		.inst_out      (inst_out)
	);

	rs_issue_selector u_selector (
		.rows       (rows),
		.issue_en   (issue_en),
		.lsq_busy   (lsq_busy),
		.pick_valid (pick_valid),
		.pick_row   (pick_row)
	);

endmodule

`default_nettype wire
